/* Makefile */
# Verilator flow for the DAC command path

TOP := tb_dqla_dac

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* project.f */
source/dqla_pkg.sv
source/current_cmd_regs.sv
source/dac_update_ctrl.sv
source/dac_spi_shifter.sv
source/dqla_dac_top.sv
verification/tb_dqla_dac.sv

/* source/current_cmd_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module current_cmd_regs (
    input  wire                    sysclk,
    input  wire                    reset,

    // Host write bus
    input  wire dqla_pkg::reg_addr_t reg_waddr,
    input  wire [31:0]             reg_wdata,
    input  wire                    reg_wen,
    input  wire                    blk_wen,     // End of block write

    // Host read bus
    input  wire dqla_pkg::reg_addr_t reg_raddr,
    output logic [31:0]            reg_rdata,

    // Toward the DAC update controller
    output dqla_pkg::cmd_bank_t    cmd_bank,
    output logic                   update_request
);

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------

    // Main space, channel 1..8, DAC control offset
    function automatic logic is_cmd_addr(input dqla_pkg::reg_addr_t a);
        return (a.space == dqla_pkg::ADDR_MAIN) &&
               (a.chan != 4'd0) &&
               (a.chan <= 4'(dqla_pkg::NUM_CHAN)) &&
               (a.offset == dqla_pkg::OFF_DAC_CTRL);
    endfunction

    logic       waddr_hit;
    logic       raddr_hit;
    logic [2:0] wr_idx;     // Channel minus one
    logic [2:0] rd_idx;

    assign waddr_hit = is_cmd_addr(reg_waddr);
    assign raddr_hit = is_cmd_addr(reg_raddr);
    assign wr_idx    = 3'(reg_waddr.chan - 4'd1);
    assign rd_idx    = 3'(reg_raddr.chan - 4'd1);

    // ------------------------------------------------------------------------
    // Command storage
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (reset) begin
            cmd_bank <= '0;                     // All channels at zero current
        end else if (reg_wen && waddr_hit) begin
            cmd_bank[wr_idx] <= reg_wdata[15:0];
        end
    end

    // Readback, zero-extended; unmapped addresses read 0
    assign reg_rdata = raddr_hit ? {16'd0, cmd_bank[rd_idx]} : 32'd0;

    // ------------------------------------------------------------------------
    // Update request
    // ------------------------------------------------------------------------

    // Block-write end marker aimed at a command register
    always_ff @(posedge sysclk) begin
        if (reset) begin
            update_request <= 1'b0;
        end else begin
            update_request <= blk_wen && waddr_hit;   // One-cycle pulse
        end
    end

    // Bus never issues a quadlet write and a block end together
    a_wen_exclusive : assert property (
        @(posedge sysclk) disable iff (reset)
        !(reg_wen && blk_wen)
    );

endmodule

`default_nettype wire

/* source/dac_spi_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_spi_shifter #(
    parameter int SCLK_HALF_PERIOD = 2      // sysclk cycles per SCLK half period
) (
    input  wire                              sysclk,
    input  wire                              reset,

    // Handshake with the update controller
    input  wire                              batch_req,
    input  wire dqla_pkg::dac_batch_t        batch,
    output logic                             batch_ack,

    // DAC chains, shared SCLK
    output logic                             dac_sclk,
    output logic [dqla_pkg::NUM_CHAINS-1:0]  dac_mosi,
    output logic [dqla_pkg::NUM_CHAINS-1:0]  dac_csn
);

    localparam int NCH     = dqla_pkg::NUM_CHAINS;
    localparam int CPC     = dqla_pkg::CHANS_PER_CHAIN;
    localparam int FBITS   = dqla_pkg::FRAME_BITS;
    localparam int SR_BITS = CPC * FBITS;                   // 96 per chain
    localparam int HCW     = (SCLK_HALF_PERIOD > 1) ? $clog2(SCLK_HALF_PERIOD) : 1;

    typedef enum logic [1:0] {
        IDLE,       // Waiting for a batch
        SELECT,     // csn low, first bit set up
        SHIFT,      // SCLK toggling
        GAP         // csn high between frames
    } shift_state_e;

    shift_state_e       state;
    logic [HCW-1:0]     half_cnt;
    logic [4:0]         bit_cnt;    // Falling edges in frame, or gap halves
    logic [1:0]         frame_cnt;  // Current DAC address
    logic               half_done;
    logic               sclk_fall;

    logic [SR_BITS-1:0] shift_reg [NCH];

    assign half_done = (half_cnt == HCW'(SCLK_HALF_PERIOD - 1));
    assign sclk_fall = (state == SHIFT) && half_done && dac_sclk;

    // ------------------------------------------------------------------------
    // Frame sequencer
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (reset) begin
            state     <= IDLE;
            half_cnt  <= '0;
            bit_cnt   <= '0;
            frame_cnt <= '0;
            batch_ack <= 1'b0;
            dac_sclk  <= 1'b0;
            dac_mosi  <= '0;
            dac_csn   <= '1;
        end else begin
            // Half-period pacing, restarted from idle
            if (state == IDLE || half_done) begin
                half_cnt <= '0;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end

            case (state)
                IDLE: begin
                    if (batch_req) begin
                        batch_ack <= 1'b1;          // Busy until the last gap ends
                        frame_cnt <= '0;
                        bit_cnt   <= '0;
                        dac_csn   <= '0;
                        for (int k = 0; k < NCH; k++) begin
                            dac_mosi[k] <= batch[k*CPC][FBITS-1];
                        end
                        state <= SELECT;
                    end
                end

                SELECT: begin
                    if (half_done) begin
                        dac_sclk <= 1'b1;           // First rising edge
                        state    <= SHIFT;
                    end
                end

                SHIFT: begin
                    if (half_done) begin
                        dac_sclk <= ~dac_sclk;
                        if (dac_sclk) begin
                            // Next bit right after the falling edge
                            for (int k = 0; k < NCH; k++) begin
                                dac_mosi[k] <= shift_reg[k][SR_BITS-2];
                            end
                            if (bit_cnt == 5'(FBITS - 1)) begin
                                bit_cnt <= '0;
                                dac_csn <= '1;      // Frame loads into the DAC
                                state   <= GAP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end

                GAP: begin
                    if (half_done) begin
                        if (bit_cnt == 5'd1) begin  // Two half periods high
                            bit_cnt <= '0;
                            if (frame_cnt == 2'(CPC - 1)) begin
                                batch_ack <= 1'b0;
                                state     <= IDLE;
                            end else begin
                                frame_cnt <= frame_cnt + 1'b1;
                                dac_csn   <= '0;
                                state     <= SELECT;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Per-chain shift registers
    // ------------------------------------------------------------------------

    // DAC address 0 sits at the top, so it goes out first
    always_ff @(posedge sysclk) begin
        if (state == IDLE && batch_req) begin
            for (int k = 0; k < NCH; k++) begin
                for (int f = 0; f < CPC; f++) begin
                    shift_reg[k][SR_BITS-1-f*FBITS -: FBITS] <= batch[k*CPC+f];
                end
            end
        end else if (sclk_fall) begin
            for (int k = 0; k < NCH; k++) begin
                shift_reg[k] <= shift_reg[k] << 1;
            end
        end
    end

    // Chains must stay framed together
    a_csn_equal : assert property (
        @(posedge sysclk) disable iff (reset)
        dac_csn[0] == dac_csn[NCH-1]
    );

    // No stray clock edges outside a frame
    a_sclk_idle_low : assert property (
        @(posedge sysclk) disable iff (reset)
        dac_csn[0] |-> !dac_sclk
    );

endmodule

`default_nettype wire

/* source/dac_update_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_update_ctrl (
    input  wire                     sysclk,
    input  wire                     reset,

    // From the command registers
    input  wire dqla_pkg::cmd_bank_t cmd_bank,
    input  wire                     update_request,

    // Four-phase handshake with the shifter
    input  wire                     batch_ack,      // Also the DAC busy flag
    output logic                    batch_req,
    output dqla_pkg::dac_batch_t    batch
);

    // ------------------------------------------------------------------------
    // Frame mapping
    // ------------------------------------------------------------------------

    // Channel c on chain k goes to DAC address c-1 of that chain
    function automatic dqla_pkg::dac_batch_t build_batch(input dqla_pkg::cmd_bank_t bank);
        dqla_pkg::dac_batch_t b;
        for (int i = 0; i < dqla_pkg::NUM_CHAN; i++) begin
            b[i].opcode   = dqla_pkg::DAC_WRITE_UPDATE;
            b[i].dac_addr = 4'(i % dqla_pkg::CHANS_PER_CHAIN);
            b[i].data     = bank[i];
        end
        return b;
    endfunction

    // ------------------------------------------------------------------------
    // Pending request and handshake
    // ------------------------------------------------------------------------

    logic pending;      // At most one request waits behind a busy shifter
    logic launch;

    // Shifter idle and no request already outstanding
    assign launch = pending && !batch_req && !batch_ack;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            pending   <= 1'b0;
            batch_req <= 1'b0;
        end else begin
            // A request in the launch cycle is covered by this batch
            if (launch) begin
                pending <= 1'b0;
            end else if (update_request) begin
                pending <= 1'b1;                // Merges with any earlier one
            end

            if (launch) begin
                batch_req <= 1'b1;
            end else if (batch_req && batch_ack) begin
                batch_req <= 1'b0;              // Shifter has latched the batch
            end
        end
    end

    // Commands sampled in the launch cycle, held until the next launch
    always_ff @(posedge sysclk) begin
        if (launch) begin
            batch <= build_batch(cmd_bank);
        end
    end

    // Request is only withdrawn after the shifter answered
    a_req_held : assert property (
        @(posedge sysclk) disable iff (reset)
        $fell(batch_req) |-> $past(batch_ack)
    );

    // Shifter may latch at any cycle of the request
    a_batch_stable : assert property (
        @(posedge sysclk) disable iff (reset)
        batch_req |=> (!batch_req || $stable(batch))
    );

endmodule

`default_nettype wire

/* source/dqla_dac_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dqla_dac_top #(
    parameter int SCLK_HALF_PERIOD = 2      // SCLK at sysclk/4 by default
) (
    input  wire                              sysclk,
    input  wire                              reset,

    // Host write bus
    input  wire dqla_pkg::reg_addr_t         reg_waddr,
    input  wire [31:0]                       reg_wdata,
    input  wire                              reg_wen,
    input  wire                              blk_wen,

    // Host read bus
    input  wire dqla_pkg::reg_addr_t         reg_raddr,
    output wire [31:0]                       reg_rdata,

    // Quad DAC chains, Q1 on bit 0, Q2 on bit 1
    output wire                              dac_sclk,
    output wire [dqla_pkg::NUM_CHAINS-1:0]   dac_mosi,
    output wire [dqla_pkg::NUM_CHAINS-1:0]   dac_csn,

    output wire                              dac_busy   // Batch in flight
);

    // ------------------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------------------

    wire dqla_pkg::cmd_bank_t  cmd_bank;
    wire                       update_request;
    wire                       batch_req;
    wire dqla_pkg::dac_batch_t batch;

    // ------------------------------------------------------------------------
    // Command registers, update control, serial output
    // ------------------------------------------------------------------------

    current_cmd_regs u_cmd_regs (
        .sysclk         (sysclk),
        .reset          (reset),
        .reg_waddr      (reg_waddr),
        .reg_wdata      (reg_wdata),
        .reg_wen        (reg_wen),
        .blk_wen        (blk_wen),
        .reg_raddr      (reg_raddr),
        .reg_rdata      (reg_rdata),
        .cmd_bank       (cmd_bank),
        .update_request (update_request)
    );

    dac_update_ctrl u_update_ctrl (
        .sysclk         (sysclk),
        .reset          (reset),
        .cmd_bank       (cmd_bank),
        .update_request (update_request),
        .batch_ack      (dac_busy),         // Ack doubles as busy
        .batch_req      (batch_req),
        .batch          (batch)
    );

    dac_spi_shifter #(
        .SCLK_HALF_PERIOD (SCLK_HALF_PERIOD)
    ) u_spi_shifter (
        .sysclk         (sysclk),
        .reset          (reset),
        .batch_req      (batch_req),
        .batch          (batch),
        .batch_ack      (dac_busy),
        .dac_sclk       (dac_sclk),
        .dac_mosi       (dac_mosi),
        .dac_csn        (dac_csn)
    );

endmodule

`default_nettype wire

/* source/dqla_pkg.sv */
`default_nettype none

package dqla_pkg;

    // ------------------------------------------------------------------------
    // Board constants
    // ------------------------------------------------------------------------

    localparam int NUM_CHAINS      = 2;     // Serial DAC chains on the board
    localparam int CHANS_PER_CHAIN = 4;     // Quad DAC per chain
    localparam int NUM_CHAN        = 8;     // Motor channels 1..8
    localparam int FRAME_BITS      = 24;    // One quad DAC command word

    // ------------------------------------------------------------------------
    // Register address map
    // ------------------------------------------------------------------------

    // Address bits 15:12
    typedef enum logic [3:0] {
        ADDR_MAIN     = 4'd0,
        ADDR_PROM_QLA = 4'd5,
        ADDR_DS       = 4'd6,
        ADDR_WAVEFORM = 4'd8
    } addr_space_e;

    // Address bits 3:0, per channel
    typedef enum logic [3:0] {
        OFF_ADC_DATA     = 4'd0,
        OFF_DAC_CTRL     = 4'd1,    // Commanded current
        OFF_MOTOR_STATUS = 4'd12
    } reg_offset_e;

    typedef struct packed {
        addr_space_e space;     // 15:12
        logic [3:0]  spare;     // 11:8
        logic [3:0]  chan;      // 7:4, zero is the board channel
        reg_offset_e offset;    // 3:0
    } reg_addr_t;

    // ------------------------------------------------------------------------
    // Command and DAC frame types
    // ------------------------------------------------------------------------

    typedef logic [15:0] cur_cmd_t;

    // Entry 0 holds channel 1
    typedef cur_cmd_t [NUM_CHAN-1:0] cmd_bank_t;

    // Write to input register and update the output
    typedef enum logic [3:0] {
        DAC_WRITE_UPDATE = 4'b0011
    } dac_opcode_e;

    // Shifted out MSB first
    typedef struct packed {
        dac_opcode_e opcode;
        logic [3:0]  dac_addr;  // DAC A..D as 0..3
        cur_cmd_t    data;
    } dac_frame_t;

    // Entry chain*CHANS_PER_CHAIN + dac_addr
    typedef dac_frame_t [NUM_CHAINS*CHANS_PER_CHAIN-1:0] dac_batch_t;

endpackage

`default_nettype wire

/* verification/tb_dqla_dac.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dqla_dac;

    localparam int MAX_CYCLES = 20000;      // About 40 batches of headroom

    logic                 sysclk;
    logic                 reset;
    dqla_pkg::reg_addr_t  reg_waddr;
    logic [31:0]          reg_wdata;
    logic                 reg_wen;
    logic                 blk_wen;
    dqla_pkg::reg_addr_t  reg_raddr;
    wire  [31:0]          reg_rdata;
    wire                  dac_sclk;
    wire  [1:0]           dac_mosi;
    wire  [1:0]           dac_csn;
    wire                  dac_busy;

    integer      seed = 32'h6cdb4046;
    string       test_name = "reset";
    int          fail_count = 0;
    int          cycle_count = 0;
    logic [15:0] model [8];         // Host view of the commands
    logic [15:0] snap [8];          // Model frozen at the start of a batch
    logic [31:0] cap_q [$];         // {chain, index, frame}

    dqla_dac_top dut (
        .sysclk    (sysclk),
        .reset     (reset),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata),
        .dac_sclk  (dac_sclk),
        .dac_mosi  (dac_mosi),
        .dac_csn   (dac_csn),
        .dac_busy  (dac_busy)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;    // 4 ns period
    end

    // ------------------------------------------------------------------------
    // Reference model and reporting
    // ------------------------------------------------------------------------

    // Write-and-update opcode, DAC address, channel command
    function automatic logic [23:0] expected_frame(input int chain, input int index,
                                                   input logic [15:0] m [8]);
        return {4'b0011, 4'(index), m[chain*4+index]};
    endfunction

    task automatic print_fail(input string line);
        $display("%s", line);
        $display("Something failed");
        fail_count++;
    endtask

    task automatic check_equal(input string what, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            print_fail($sformatf("ERROR %s: expected %h, actual %h", what, exp_val, act_val));
            $fatal(1);
        end
    endtask

    always @(posedge sysclk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            print_fail($sformatf("Timeout: run went past %0d cycles in %s",
                                 MAX_CYCLES, test_name));
            $fatal(1);
        end
    end

    // ------------------------------------------------------------------------
    // Serial capture, both chains
    // ------------------------------------------------------------------------

    logic        prev_sclk;
    logic [1:0]  prev_csn;
    logic        prev_busy;
    logic [23:0] rx_sr [2];
    int          rx_bits [2];
    int          frame_idx [2];
    int          batch_count;

    // Sampled at negedge, well away from the DUT's edges
    always @(negedge sysclk) begin
        if (reset) begin
            prev_sclk   = 1'b0;
            prev_csn    = 2'b11;
            prev_busy   = 1'b0;
            batch_count = 0;
            for (int k = 0; k < 2; k++) begin
                rx_sr[k]     = '0;
                rx_bits[k]   = 0;
                frame_idx[k] = 0;
            end
        end else begin
            if (dac_busy && !prev_busy) begin
                snap = model;               // Commands this batch must carry
                batch_count++;
                frame_idx[0] = 0;
                frame_idx[1] = 0;
            end
            for (int k = 0; k < 2; k++) begin
                if (prev_csn[k] && !dac_csn[k]) begin
                    rx_bits[k] = 0;
                end
                if (!prev_sclk && dac_sclk && !dac_csn[k]) begin
                    rx_sr[k] = {rx_sr[k][22:0], dac_mosi[k]};   // MSB first
                    rx_bits[k]++;
                end
                if (!prev_csn[k] && dac_csn[k]) begin
                    assert (rx_bits[k] == 24) else begin
                        print_fail($sformatf("Chain %0d frame had %0d clocks instead of 24 in %s",
                                             k, rx_bits[k], test_name));
                        $fatal(1);
                    end
                    cap_q.push_back({4'(k), 4'(frame_idx[k]), rx_sr[k]});
                    frame_idx[k]++;
                end
            end
            if (!dac_busy && prev_busy) begin
                assert (frame_idx[0] == 4 && frame_idx[1] == 4) else begin
                    print_fail($sformatf("Batch ended after %0d and %0d frames in %s",
                                         frame_idx[0], frame_idx[1], test_name));
                    $fatal(1);
                end
            end
            prev_sclk = dac_sclk;
            prev_csn  = dac_csn;
            prev_busy = dac_busy;
        end
    end

    // Comparator
    always @(posedge sysclk) begin
        logic [31:0] entry;
        int          chain;
        int          index;
        while (cap_q.size() > 0) begin
            entry = cap_q.pop_front();
            chain = int'(entry[31:28]);
            index = int'(entry[27:24]);
            check_equal($sformatf("%s chain %0d frame %0d", test_name, chain, index),
                        32'(expected_frame(chain, index, snap)), {8'd0, entry[23:0]});
        end
    end

    // ------------------------------------------------------------------------
    // Bus tasks
    // ------------------------------------------------------------------------

    function automatic dqla_pkg::reg_addr_t make_addr(input dqla_pkg::addr_space_e space,
                                                      input int chan,
                                                      input dqla_pkg::reg_offset_e offset);
        dqla_pkg::reg_addr_t a;
        a.space  = space;
        a.spare  = 4'd0;
        a.chan   = 4'(chan);
        a.offset = offset;
        return a;
    endfunction

    function automatic dqla_pkg::reg_addr_t cmd_addr(input int chan);
        return make_addr(dqla_pkg::ADDR_MAIN, chan, dqla_pkg::OFF_DAC_CTRL);
    endfunction

    task automatic write_reg(input dqla_pkg::reg_addr_t addr, input logic [31:0] data);
        @(posedge sysclk);
        reg_waddr <= addr;
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        @(posedge sysclk);
        reg_wen   <= 1'b0;
    endtask

    task automatic write_random_cmds(input int first, input int last);
        logic [31:0] rnd;
        for (int ch = first; ch <= last; ch++) begin
            rnd = $random(seed);            // Upper half must be dropped
            write_reg(cmd_addr(ch), rnd);
            model[ch-1] = rnd[15:0];
        end
    endtask

    task automatic request_update(input dqla_pkg::reg_addr_t addr);
        @(posedge sysclk);
        reg_waddr <= addr;
        blk_wen   <= 1'b1;
        @(posedge sysclk);
        blk_wen   <= 1'b0;
    endtask

    task automatic check_readback();
        logic [31:0] data;
        for (int ch = 1; ch <= 8; ch++) begin
            @(posedge sysclk);
            reg_raddr <= cmd_addr(ch);
            @(negedge sysclk);              // Combinational read settles
            data = reg_rdata;
            check_equal($sformatf("%s readback ch %0d", test_name, ch),
                        {16'd0, model[ch-1]}, data);
        end
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        do begin
            @(posedge sysclk);
            n++;
            if (n > limit) begin
                print_fail($sformatf("dac_busy did not go to %0d within %0d cycles in %s",
                                     level, limit, test_name));
                $fatal(1);
            end
        end while (dac_busy !== level);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin
        int base;
        reset     = 1'b1;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_wen   = 1'b0;
        blk_wen   = 1'b0;
        reg_raddr = '0;
        for (int i = 0; i < 8; i++) begin
            model[i] = '0;
            snap[i]  = '0;
        end
        repeat (16) @(posedge sysclk);
        reset <= 1'b0;
        repeat (2) @(posedge sysclk);

        test_name = "reset_state";
        @(negedge sysclk);
        check_equal({test_name, " csn"}, 32'd3, {30'd0, dac_csn});
        check_equal({test_name, " busy"}, 32'd0, {31'd0, dac_busy});
        check_readback();

        test_name = "write_readback";
        write_random_cmds(1, 8);
        check_readback();
        write_reg(make_addr(dqla_pkg::ADDR_MAIN, 0, dqla_pkg::OFF_DAC_CTRL), $random(seed));
        write_reg(make_addr(dqla_pkg::ADDR_MAIN, 3, dqla_pkg::OFF_ADC_DATA), $random(seed));
        write_reg(make_addr(dqla_pkg::ADDR_PROM_QLA, 5, dqla_pkg::OFF_DAC_CTRL), $random(seed));
        check_readback();                   // Illegal writes left no trace

        test_name = "update_frames";
        for (int pass = 0; pass < 2; pass++) begin
            write_random_cmds(1, 8);
            request_update(cmd_addr(pass == 0 ? 1 : 8));
            wait_busy(1'b1, 100);
            wait_busy(1'b0, 2000);
        end

        test_name = "non_cmd_block";
        request_update(make_addr(dqla_pkg::ADDR_MAIN, 3, dqla_pkg::OFF_ADC_DATA));
        request_update(make_addr(dqla_pkg::ADDR_DS, 2, dqla_pkg::OFF_DAC_CTRL));
        repeat (200) begin
            @(negedge sysclk);
            assert (dac_csn == 2'b11 && !dac_busy) else begin
                print_fail("DAC chip select went active after a non-command block write");
                $fatal(1);
            end
        end

        test_name = "write_during_shift";
        write_random_cmds(1, 8);
        request_update(cmd_addr(4));
        wait_busy(1'b1, 100);
        write_random_cmds(1, 8);            // No update request follows
        wait_busy(1'b0, 2000);
        check_readback();

        test_name = "merged_requests";
        write_random_cmds(1, 8);
        request_update(cmd_addr(2));
        wait_busy(1'b1, 100);
        base = batch_count;
        write_random_cmds(1, 4);
        request_update(cmd_addr(3));
        write_random_cmds(5, 8);
        request_update(cmd_addr(7));
        assert (dac_busy) else begin
            print_fail("Batch finished before both merged requests were issued");
            $fatal(1);
        end
        wait_busy(1'b0, 2000);
        wait_busy(1'b1, 100);               // Pending request served next
        wait_busy(1'b0, 2000);
        repeat (300) @(posedge sysclk);
        check_equal({test_name, " batches"}, 32'(base + 1), 32'(batch_count));

        if (fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
